// File: bench/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;

    // one test case: stimulus fields, then expected bundle
    // enables is {regWrite, memWrite, aluSrc}, jumps is {pcSrc, isJalr}
    // addrRule is {rdAddr1, rdAddr2, wrAddr}, 1 = instruction field, 0 = x0
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic f7b5;
        rvIsaPkg::pcT pcNext;
        logic zero;
        logic [2:0] enables;
        logic [1:0] jumps;
        logic [2:0] addrRule;
        rvCtrlPkg::aluCtrlT aluCtrl;
        rvCtrlPkg::resultSrcT resultSrc;
        rvCtrlPkg::immSelT immSel;
        rvCtrlPkg::flowKindT flowKind;
    } caseRowT;

    localparam int waitLimit = 16;

    logic clk = 1'b0;
    logic rstN;
    logic instrValid;
    rvIsaPkg::instrWordT instr;
    rvIsaPkg::pcT pcNext;
    logic zero;
    rvCtrlPkg::ctrlBundleT ctrl;
    logic ctrlValid;
    logic pcSrc;
    logic isJalr;

    caseRowT rows [26];
    logic [15:0] lfsr = 16'd69;
    int checkErrors = 0;
    int badRows = 0;
    int rowIdx = -1;
    logic timedOut = 1'b0;

    decodeStage i_dut (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instr(instr),
        .pcNext(pcNext),
        .zero(zero),
        .ctrl(ctrl),
        .ctrlValid(ctrlValid),
        .pcSrc(pcSrc),
        .isJalr(isJalr)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsrNext(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %0t row %0d %s got %0h expected %0h",
                     $time, rowIdx, what, got, exp);
            checkErrors++;
        end
    endtask

    task automatic loadTable();
        rows[0] = '{rvIsaPkg::opReg, 3'b000, 1'b0, 16'h0104, 1'b0, 3'b100, 2'b00, 3'b111,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resAlu, rvCtrlPkg::immI, rvCtrlPkg::flowNone};
        rows[1] = '{rvIsaPkg::opReg, 3'b000, 1'b1, 16'h0108, 1'b0, 3'b100, 2'b00, 3'b111,
            rvCtrlPkg::aluSub, rvCtrlPkg::resAlu, rvCtrlPkg::immI, rvCtrlPkg::flowNone};
        // sra, funct7 bit 5 on top of 101
        rows[2] = '{rvIsaPkg::opReg, 3'b101, 1'b1, 16'h010c, 1'b0, 3'b100, 2'b00, 3'b111,
            4'b1101, rvCtrlPkg::resAlu, rvCtrlPkg::immI, rvCtrlPkg::flowNone};
        rows[3] = '{rvIsaPkg::opImm, 3'b000, 1'b0, 16'h0110, 1'b0, 3'b101, 2'b00, 3'b101,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resAlu, rvCtrlPkg::immI, rvCtrlPkg::flowNone};
        // srai, funct7 bit 5 must not reach aluCtrl
        rows[4] = '{rvIsaPkg::opImm, 3'b101, 1'b1, 16'h0114, 1'b0, 3'b101, 2'b00, 3'b101,
            4'b0101, rvCtrlPkg::resAlu, rvCtrlPkg::immI, rvCtrlPkg::flowNone};
        rows[5] = '{rvIsaPkg::opLoad, 3'b010, 1'b0, 16'h0118, 1'b0, 3'b101, 2'b00, 3'b101,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resMem, rvCtrlPkg::immLd, rvCtrlPkg::flowNone};
        rows[6] = '{rvIsaPkg::opStore, 3'b010, 1'b0, 16'h011c, 1'b0, 3'b011, 2'b00, 3'b110,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resMem, rvCtrlPkg::immS, rvCtrlPkg::flowNone};
        rows[7] = '{rvIsaPkg::opJal, 3'b000, 1'b0, 16'h0120, 1'b0, 3'b101, 2'b10, 3'b001,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resPc, rvCtrlPkg::immJ, rvCtrlPkg::flowJal};
        rows[8] = '{rvIsaPkg::opJalr, 3'b000, 1'b0, 16'h0124, 1'b1, 3'b001, 2'b11, 3'b100,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resAlu, rvCtrlPkg::immLd, rvCtrlPkg::flowJalr};
        rows[9] = '{rvIsaPkg::opLui, 3'b000, 1'b0, 16'h0200, 1'b0, 3'b101, 2'b00, 3'b001,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resAlu, rvCtrlPkg::immU, rvCtrlPkg::flowNone};
        rows[10] = '{rvIsaPkg::opAuipc, 3'b000, 1'b0, 16'h0200, 1'b0, 3'b101, 2'b00, 3'b001,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resAlu, rvCtrlPkg::immU, rvCtrlPkg::flowNone};
        // branches, each with zero low then high
        rows[11] = '{rvIsaPkg::opBranch, 3'b000, 1'b0, 16'h0300, 1'b0, 3'b000, 2'b00, 3'b110,
            rvCtrlPkg::aluSub, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBeq};
        rows[12] = '{rvIsaPkg::opBranch, 3'b000, 1'b0, 16'h0304, 1'b1, 3'b000, 2'b10, 3'b110,
            rvCtrlPkg::aluSub, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBeq};
        rows[13] = '{rvIsaPkg::opBranch, 3'b001, 1'b0, 16'h0308, 1'b0, 3'b000, 2'b10, 3'b110,
            rvCtrlPkg::aluSub, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBne};
        rows[14] = '{rvIsaPkg::opBranch, 3'b001, 1'b0, 16'h030c, 1'b1, 3'b000, 2'b00, 3'b110,
            rvCtrlPkg::aluSub, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBne};
        rows[15] = '{rvIsaPkg::opBranch, 3'b100, 1'b0, 16'h0310, 1'b0, 3'b000, 2'b00, 3'b110,
            rvCtrlPkg::aluLtSigned, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBlt};
        rows[16] = '{rvIsaPkg::opBranch, 3'b100, 1'b0, 16'h0314, 1'b1, 3'b000, 2'b10, 3'b110,
            rvCtrlPkg::aluLtSigned, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBlt};
        rows[17] = '{rvIsaPkg::opBranch, 3'b101, 1'b0, 16'h0318, 1'b0, 3'b000, 2'b10, 3'b110,
            rvCtrlPkg::aluLtSigned, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBge};
        rows[18] = '{rvIsaPkg::opBranch, 3'b101, 1'b0, 16'h031c, 1'b1, 3'b000, 2'b00, 3'b110,
            rvCtrlPkg::aluLtSigned, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBge};
        rows[19] = '{rvIsaPkg::opBranch, 3'b110, 1'b0, 16'h0320, 1'b0, 3'b000, 2'b00, 3'b110,
            rvCtrlPkg::aluLtUnsigned, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBltu};
        rows[20] = '{rvIsaPkg::opBranch, 3'b110, 1'b0, 16'h0324, 1'b1, 3'b000, 2'b10, 3'b110,
            rvCtrlPkg::aluLtUnsigned, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBltu};
        rows[21] = '{rvIsaPkg::opBranch, 3'b111, 1'b0, 16'h0328, 1'b0, 3'b000, 2'b10, 3'b110,
            rvCtrlPkg::aluLtUnsigned, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBgeu};
        rows[22] = '{rvIsaPkg::opBranch, 3'b111, 1'b0, 16'h032c, 1'b1, 3'b000, 2'b00, 3'b110,
            rvCtrlPkg::aluLtUnsigned, rvCtrlPkg::resAlu, rvCtrlPkg::immB, rvCtrlPkg::flowBgeu};
        // no-op rows, all addresses x0 and immOp cleared
        rows[23] = '{7'b1111111, 3'b000, 1'b0, 16'h0400, 1'b1, 3'b001, 2'b00, 3'b000,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resAlu, rvCtrlPkg::immI, rvCtrlPkg::flowNone};
        rows[24] = '{rvIsaPkg::opBranch, 3'b010, 1'b0, 16'h0404, 1'b1, 3'b001, 2'b00, 3'b000,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resAlu, rvCtrlPkg::immI, rvCtrlPkg::flowNone};
        rows[25] = '{rvIsaPkg::opBranch, 3'b011, 1'b0, 16'h0408, 1'b0, 3'b001, 2'b00, 3'b000,
            rvCtrlPkg::aluAdd, rvCtrlPkg::resAlu, rvCtrlPkg::immI, rvCtrlPkg::flowNone};
    endtask

    task automatic runRow(input int idx);
        caseRowT row;
        logic [31:0] bits;
        rvIsaPkg::instrWordT word;
        logic [31:0] flatWord;
        logic [rvIsaPkg::immFieldWidth-1:0] expImm;
        rvIsaPkg::pcT expAuipc;
        int tries;

        row = rows[idx];
        // random register fields and spare funct7 bits
        takeBits(21, bits);
        word.r.opcode = row.opcode;
        word.r.funct3 = row.funct3;
        word.r.rd = bits[4:0];
        word.r.rs1 = bits[9:5];
        word.r.rs2 = bits[14:10];
        word.r.funct7 = {bits[20], row.f7b5, bits[19:15]};
        flatWord = word;
        // raw field is everything above the opcode, zero for a no-op
        expImm = (row.addrRule == 3'b000) ? '0 : flatWord[31:7];
        expAuipc = (row.opcode == rvIsaPkg::opAuipc) ? row.pcNext - 16'd4 : '0;

        @(posedge clk);
        #1;
        instr = word;
        pcNext = row.pcNext;
        zero = row.zero;
        instrValid = 1'b1;
        tries = 0;
        do begin
            @(posedge clk);
            #1;
            instrValid = 1'b0;
            // sample mid cycle
            #3;
            tries++;
        end while (!ctrlValid && tries < waitLimit);
        if (!ctrlValid) begin
            $display("timeout: no valid bundle for row %0d after %0d cycles", idx, tries);
            timedOut = 1'b1;
            return;
        end

        // bundle is due exactly one edge after the instruction is sampled
        checkValue("latency", tries, 1);
        checkValue("rdAddr1", ctrl.rdAddr1, row.addrRule[2] ? word.r.rs1 : 5'd0);
        checkValue("rdAddr2", ctrl.rdAddr2, row.addrRule[1] ? word.r.rs2 : 5'd0);
        checkValue("wrAddr", ctrl.wrAddr, row.addrRule[0] ? word.r.rd : 5'd0);
        checkValue("regWrite", ctrl.regWrite, row.enables[2]);
        checkValue("memWrite", ctrl.memWrite, row.enables[1]);
        checkValue("aluSrc", ctrl.aluSrc, row.enables[0]);
        checkValue("aluCtrl", ctrl.aluCtrl, row.aluCtrl);
        checkValue("resultSrc", ctrl.resultSrc, row.resultSrc);
        checkValue("immOp", ctrl.immOp, expImm);
        checkValue("immSel", ctrl.immSel, row.immSel);
        checkValue("auipcPc", ctrl.auipcPc, expAuipc);
        checkValue("flowKind", ctrl.flowKind, row.flowKind);
        checkValue("pcSrc", pcSrc, row.jumps[1]);
        checkValue("isJalr", isJalr, row.jumps[0]);
    endtask

    initial begin
        int errBefore;

        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        pcNext = '0;
        zero = 1'b0;
        loadTable();

        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        // idle cycle out of reset, nothing valid yet
        @(posedge clk);
        #3;
        checkValue("ctrlValid", ctrlValid, 1'b0);
        checkValue("regWrite", ctrl.regWrite, 1'b0);
        checkValue("memWrite", ctrl.memWrite, 1'b0);
        checkValue("pcSrc", pcSrc, 1'b0);
        checkValue("isJalr", isJalr, 1'b0);
        $display("reset: %s", (checkErrors == 0) ? "ok" : "error");

        for (int i = 0; i < $size(rows); i++) begin
            rowIdx = i;
            errBefore = checkErrors;
            runRow(i);
            if (timedOut) begin
                break;
            end
            if (checkErrors != errBefore) begin
                badRows++;
            end
            $display("row %0d opcode %b funct3 %b zero %b: %s", i, rows[i].opcode,
                     rows[i].funct3, rows[i].zero, (checkErrors == errBefore) ? "ok" : "error");
        end

        $display("%0d rows, %0d bad rows, %0d check errors, %0d assertion errors",
                 rowIdx + 1, badRows, checkErrors, i_dut.i_checker.failCount);
        if (timedOut || checkErrors != 0 || i_dut.i_checker.failCount != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

// File: bench/decodeStage_checker.sv
`timescale 1ns/1ps

module decodeStageChecker (
    input logic clk,
    input logic rstN,
    input rvCtrlPkg::ctrlBundleT ctrl,
    input logic ctrlValid,
    input logic pcSrc,
    input logic isJalr
);

    // failed property count
    int failCount = 0;

    // a bubble must never write anything
    writeNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.regWrite || ctrl.memWrite) |-> ctrlValid)
        else begin
            $error("write enable high on a bundle without ctrlValid");
            failCount++;
        end

    // no instruction class writes both register file and memory
    oneWriteTarget: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.regWrite && ctrl.memWrite))
        else begin
            $error("regWrite and memWrite high together");
            failCount++;
        end

    // jalr is a jump, so it always redirects
    jalrRedirects: assert property (@(posedge clk) disable iff (!rstN)
        isJalr |-> pcSrc)
        else begin
            $error("isJalr high while pcSrc low");
            failCount++;
        end

    // first cycle out of reset carries no bundle
    quietAfterReset: assert property (@(posedge clk) $rose(rstN) |=> !ctrlValid)
        else begin
            $error("ctrlValid high in the cycle after reset");
            failCount++;
        end

endmodule

bind decodeStage decodeStageChecker i_checker (
    .clk(clk),
    .rstN(rstN),
    .ctrl(ctrl),
    .ctrlValid(ctrlValid),
    .pcSrc(pcSrc),
    .isJalr(isJalr)
);

// File: source/branchResolver.sv
`timescale 1ns/1ps

module branchResolver (
    input rvCtrlPkg::flowKindT flowKind,
    input logic zero,
    output logic pcSrc,
    output logic isJalr
);

    // zero is the execute result for this same bundle
    always_comb begin
        case (flowKind)
            // jumps always redirect
            rvCtrlPkg::flowJal,
            rvCtrlPkg::flowJalr: pcSrc = 1'b1;
            // taken when the compare holds
            rvCtrlPkg::flowBeq,
            rvCtrlPkg::flowBlt,
            rvCtrlPkg::flowBltu: pcSrc = zero;
            // opposite polarity of the pair above
            rvCtrlPkg::flowBne,
            rvCtrlPkg::flowBge,
            rvCtrlPkg::flowBgeu: pcSrc = ~zero;
            default: pcSrc = 1'b0;
        endcase
    end

    // target comes from rs1 plus imm instead of pc plus imm
    assign isJalr = (flowKind == rvCtrlPkg::flowJalr);

endmodule

// File: source/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
    input rvIsaPkg::instrWordT instr,
    input rvIsaPkg::pcT pcNext,
    output rvCtrlPkg::ctrlBundleT next
);

    // flat copy of the word for slicing the raw immediate
    logic [rvIsaPkg::instrWidth-1:0] rawWord;
    logic [rvIsaPkg::immFieldWidth-1:0] immField;

    assign rawWord = instr;
    // immediate bits are scattered per format, sign extend sorts them out later
    assign immField = rawWord[rvIsaPkg::instrWidth-1 -: rvIsaPkg::immFieldWidth];

    always_comb begin
        rvCtrlPkg::aluCtrlT brAlu;
        rvCtrlPkg::flowKindT brFlow;

        brAlu = rvCtrlPkg::aluSub;
        brFlow = rvCtrlPkg::flowNone;
        // anything not matched below stays a no-op
        next = rvCtrlPkg::nopBundle;

        case (instr.r.opcode)
            rvIsaPkg::opReg: begin
                next.rdAddr1 = instr.r.rs1;
                next.rdAddr2 = instr.r.rs2;
                next.wrAddr = instr.r.rd;
                next.regWrite = 1'b1;
                // both operands from the register file
                next.aluSrc = 1'b0;
                // funct7 bit 5 splits add/sub and srl/sra
                next.aluCtrl = {instr.r.funct7[5], instr.r.funct3};
                next.immOp = immField;
            end

            rvIsaPkg::opImm: begin
                next.rdAddr1 = instr.r.rs1;
                next.rdAddr2 = rvIsaPkg::regZero;
                next.wrAddr = instr.r.rd;
                next.regWrite = 1'b1;
                next.aluSrc = 1'b1;
                // no sub for immediates so top bit is forced low
                next.aluCtrl = {1'b0, instr.r.funct3};
                next.immOp = immField;
                next.immSel = rvCtrlPkg::immI;
            end

            rvIsaPkg::opStore: begin
                // rs1 is the base, rs2 the store data
                next.rdAddr1 = instr.r.rs1;
                next.rdAddr2 = instr.r.rs2;
                next.wrAddr = rvIsaPkg::regZero;
                next.memWrite = 1'b1;
                next.aluSrc = 1'b1;
                // address is base plus offset
                next.aluCtrl = rvCtrlPkg::aluAdd;
                next.resultSrc = rvCtrlPkg::resMem;
                next.immOp = immField;
                next.immSel = rvCtrlPkg::immS;
            end

            rvIsaPkg::opLoad: begin
                next.rdAddr1 = instr.r.rs1;
                next.rdAddr2 = rvIsaPkg::regZero;
                next.wrAddr = instr.r.rd;
                next.regWrite = 1'b1;
                // memory is only read here
                next.memWrite = 1'b0;
                next.aluSrc = 1'b1;
                next.aluCtrl = rvCtrlPkg::aluAdd;
                next.resultSrc = rvCtrlPkg::resMem;
                next.immOp = immField;
                next.immSel = rvCtrlPkg::immLd;
            end

            rvIsaPkg::opJal: begin
                next.rdAddr1 = rvIsaPkg::regZero;
                next.rdAddr2 = rvIsaPkg::regZero;
                // link address goes to rd
                next.wrAddr = instr.r.rd;
                next.regWrite = 1'b1;
                next.aluSrc = 1'b1;
                next.resultSrc = rvCtrlPkg::resPc;
                next.immOp = immField;
                next.immSel = rvCtrlPkg::immJ;
                next.flowKind = rvCtrlPkg::flowJal;
            end

            rvIsaPkg::opJalr: begin
                // target is rs1 plus the I immediate
                next.rdAddr1 = instr.r.rs1;
                next.rdAddr2 = rvIsaPkg::regZero;
                next.wrAddr = rvIsaPkg::regZero;
                next.regWrite = 1'b0;
                next.aluSrc = 1'b1;
                next.immOp = immField;
                next.immSel = rvCtrlPkg::immLd;
                next.flowKind = rvCtrlPkg::flowJalr;
            end

            rvIsaPkg::opLui, rvIsaPkg::opAuipc: begin
                // x0 plus the upper immediate
                next.rdAddr1 = rvIsaPkg::regZero;
                next.rdAddr2 = rvIsaPkg::regZero;
                next.wrAddr = instr.u.rd;
                next.regWrite = 1'b1;
                next.aluSrc = 1'b1;
                next.aluCtrl = rvCtrlPkg::aluAdd;
                next.immOp = immField;
                next.immSel = rvCtrlPkg::immU;
                // pcNext is already pc plus 4, step back to this instruction
                if (instr.u.opcode == rvIsaPkg::opAuipc) begin
                    next.auipcPc = pcNext - rvIsaPkg::pcT'(4);
                end
            end

            rvIsaPkg::opBranch: begin
                // eq/ne subtract, the rest use set-less-than
                case (instr.r.funct3)
                    rvIsaPkg::f3Beq: begin
                        brAlu = rvCtrlPkg::aluSub;
                        brFlow = rvCtrlPkg::flowBeq;
                    end
                    rvIsaPkg::f3Bne: begin
                        brAlu = rvCtrlPkg::aluSub;
                        brFlow = rvCtrlPkg::flowBne;
                    end
                    rvIsaPkg::f3Blt: begin
                        brAlu = rvCtrlPkg::aluLtSigned;
                        brFlow = rvCtrlPkg::flowBlt;
                    end
                    rvIsaPkg::f3Bge: begin
                        brAlu = rvCtrlPkg::aluLtSigned;
                        brFlow = rvCtrlPkg::flowBge;
                    end
                    rvIsaPkg::f3Bltu: begin
                        brAlu = rvCtrlPkg::aluLtUnsigned;
                        brFlow = rvCtrlPkg::flowBltu;
                    end
                    rvIsaPkg::f3Bgeu: begin
                        brAlu = rvCtrlPkg::aluLtUnsigned;
                        brFlow = rvCtrlPkg::flowBgeu;
                    end
                    default: begin
                        // 010 and 011 fall through as a no-op
                        brFlow = rvCtrlPkg::flowNone;
                    end
                endcase

                if (brFlow != rvCtrlPkg::flowNone) begin
                    next.rdAddr1 = instr.r.rs1;
                    next.rdAddr2 = instr.r.rs2;
                    next.wrAddr = rvIsaPkg::regZero;
                    next.aluSrc = 1'b0;
                    next.aluCtrl = brAlu;
                    next.immOp = immField;
                    next.immSel = rvCtrlPkg::immB;
                    next.flowKind = brFlow;
                end
            end

            default: begin
                next = rvCtrlPkg::nopBundle;
            end
        endcase
    end

endmodule

// File: source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input logic clk,
    input logic rstN,
    input logic instrValid,
    input rvIsaPkg::instrWordT instr,
    input rvIsaPkg::pcT pcNext,
    // from execute, same cycle as the registered bundle
    input logic zero,
    output rvCtrlPkg::ctrlBundleT ctrl,
    output logic ctrlValid,
    output logic pcSrc,
    output logic isJalr
);

    // decoded bundle before the pipeline register
    rvCtrlPkg::ctrlBundleT nextCtrl;

    controlDecoder i_controlDecoder (
        .instr(instr),
        .pcNext(pcNext),
        .next(nextCtrl)
    );

    idExRegister i_idExRegister (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .next(nextCtrl),
        .ctrl(ctrl),
        .ctrlValid(ctrlValid)
    );

    // resolves against the registered flow kind
    branchResolver i_branchResolver (
        .flowKind(ctrl.flowKind),
        .zero(zero),
        .pcSrc(pcSrc),
        .isJalr(isJalr)
    );

endmodule

// File: source/idExRegister.sv
`timescale 1ns/1ps

module idExRegister (
    input logic clk,
    input logic rstN,
    input logic instrValid,
    input rvCtrlPkg::ctrlBundleT next,
    output rvCtrlPkg::ctrlBundleT ctrl,
    output logic ctrlValid
);

    // ID/EX boundary, the only state in the stage
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // no-op keeps write enables low and flow at none
            ctrl <= rvCtrlPkg::nopBundle;
            ctrlValid <= 1'b0;
        end else if (instrValid) begin
            ctrl <= next;
            ctrlValid <= 1'b1;
        end else begin
            // bubble when nothing was fetched
            ctrl <= rvCtrlPkg::nopBundle;
            ctrlValid <= 1'b0;
        end
    end

endmodule

// File: source/rvCtrlPkg.sv
package rvCtrlPkg;

    // alu control, funct7 bit 5 on top of funct3 for register ops
    typedef logic [3:0] aluCtrlT;
    localparam aluCtrlT aluAdd = 4'b0000;
    localparam aluCtrlT aluSub = 4'b1000;
    // set-less-than codes, zero flag comes back high when the compare holds
    localparam aluCtrlT aluLtSigned = 4'b0010;
    localparam aluCtrlT aluLtUnsigned = 4'b0011;

    // immediate format select for the sign extend unit
    typedef logic [2:0] immSelT;
    localparam immSelT immI = 3'b000;
    localparam immSelT immU = 3'b001;
    localparam immSelT immS = 3'b010;
    localparam immSelT immJ = 3'b011;
    // 12 bit I form as used by loads and jalr
    localparam immSelT immLd = 3'b100;
    localparam immSelT immB = 3'b111;

    // writeback source
    typedef logic [1:0] resultSrcT;
    localparam resultSrcT resAlu = 2'b00;
    localparam resultSrcT resMem = 2'b01;
    localparam resultSrcT resPc = 2'b10;

    // control flow kind, resolved after the ID/EX register
    typedef enum logic [3:0] {
        flowNone = 4'd0,
        flowJal = 4'd1,
        flowJalr = 4'd2,
        flowBeq = 4'd3,
        flowBne = 4'd4,
        flowBlt = 4'd5,
        flowBge = 4'd6,
        flowBltu = 4'd7,
        flowBgeu = 4'd8
    } flowKindT;

    // everything execute needs for one instruction
    typedef struct packed {
        rvIsaPkg::regAddrT rdAddr1;
        rvIsaPkg::regAddrT rdAddr2;
        rvIsaPkg::regAddrT wrAddr;
        logic regWrite;
        logic memWrite;
        // high selects the immediate as second alu operand
        logic aluSrc;
        aluCtrlT aluCtrl;
        resultSrcT resultSrc;
        logic [rvIsaPkg::immFieldWidth-1:0] immOp;
        immSelT immSel;
        // base pc for auipc, zero otherwise
        rvIsaPkg::pcT auipcPc;
        flowKindT flowKind;
    } ctrlBundleT;

    // add zero to x0 with nothing written, used for bubbles and bad opcodes
    localparam ctrlBundleT nopBundle = '{
        rdAddr1: '0,
        rdAddr2: '0,
        wrAddr: '0,
        regWrite: 1'b0,
        memWrite: 1'b0,
        aluSrc: 1'b1,
        aluCtrl: aluAdd,
        resultSrc: resAlu,
        immOp: '0,
        immSel: immI,
        auipcPc: '0,
        flowKind: flowNone
    };

endpackage

// File: source/rvIsaPkg.sv
package rvIsaPkg;

    // instruction word and datapath widths
    localparam int instrWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int pcWidth = 16;
    // raw immediate field is everything above opcode, bits 31 down to 7
    localparam int immFieldWidth = 25;

    typedef logic [regAddrWidth-1:0] regAddrT;
    typedef logic [pcWidth-1:0] pcT;

    // x0 reads as zero and swallows writes
    localparam regAddrT regZero = '0;

    // major opcodes
    localparam logic [6:0] opReg = 7'b0110011;
    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opJal = 7'b1101111;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;
    localparam logic [6:0] opBranch = 7'b1100011;

    // branch funct3, 010 and 011 are unused encodings
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // register format view
    // also covers I, S and B since rs1, funct3 and opcode sit in the same place
    typedef struct packed {
        logic [6:0] funct7;
        regAddrT rs2;
        regAddrT rs1;
        logic [2:0] funct3;
        regAddrT rd;
        logic [6:0] opcode;
    } rFormatT;

    // upper immediate view for lui and auipc
    typedef struct packed {
        logic [19:0] upperImm;
        regAddrT rd;
        logic [6:0] opcode;
    } uFormatT;

    // one instruction word, two ways of reading it
    typedef union packed {
        rFormatT r;
        uFormatT u;
    } instrWordT;

endpackage

// File: vlog.f
source/rvIsaPkg.sv
source/rvCtrlPkg.sv
source/controlDecoder.sv
source/idExRegister.sv
source/branchResolver.sv
source/decodeStage.sv
bench/decodeStage_checker.sv
bench/decodeStageTb.sv
